//--- logic/switch_macros.svh
// ----------------------------------------------------------------------
// switch sizing
// port, priority, beat and buffer slot dimensions shared by all blocks
// ----------------------------------------------------------------------
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

`define NUM_PORTS     4
`define NUM_PRIO      4
`define DATA_W        32
`define MAX_BEATS     8
`define NUM_SLOTS     16
`define IN_FIFO_DEPTH 16

`define PORT_W        2     // log2 NUM_PORTS
`define PRIO_W        2     // log2 NUM_PRIO
`define SLOT_W        4     // log2 NUM_SLOTS
`define BEAT_W        3     // log2 MAX_BEATS
`define LEN_W         4     // 1..MAX_BEATS
`define ADDR_W        7     // slot and beat index

`endif

//--- logic/switch_pkg.sv
// ----------------------------------------------------------------------
// switch types
// beat on the wire, stored packet descriptor, scheduler settings
// ----------------------------------------------------------------------
`include "switch_macros.svh"

package switch_pkg;

    typedef struct packed {
        logic               sop;
        logic               eop;
        logic [`DATA_W-1:0] data;
    } beat_t;

    typedef struct packed {
        logic [`SLOT_W-1:0] slot;
        logic [`LEN_W-1:0]  len;    // beats, header included
        logic [`PORT_W-1:0] port;
        logic [`PRIO_W-1:0] prio;
    } pkt_desc_t;

    typedef struct packed {
        logic                       mode;   // 0 strict priority, 1 wrr
        logic [`NUM_PRIO-1:0][3:0]  weight;
    } sched_cfg_t;

endpackage

//--- logic/sync_fifo.sv
// ----------------------------------------------------------------------
// synchronous fifo
// circular buffer of any packed entry type, optional complete-packet
// count for ingress use
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module sync_fifo
    import switch_pkg::*;
#(
    parameter type entry_t    = beat_t,
    parameter int  DEPTH      = `IN_FIFO_DEPTH,
    parameter bit  COUNT_PKTS = 1'b0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  entry_t                 push_data,
    input  logic                   pop,
    output entry_t                 head,
    output logic                   not_empty,
    output logic [$clog2(DEPTH):0] free_count,
    output logic                   pkt_avail
);
    localparam int PTR_W = $clog2(DEPTH);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign head       = mem[rd_ptr];
    assign not_empty  = (count != '0);
    assign free_count = (PTR_W+1)'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    generate
        if (COUNT_PKTS) begin : g_pkt_cnt
            logic [PTR_W:0] eop_cnt;    // packets fully inside
            logic           eop_in;
            logic           eop_out;

            assign eop_in    = push && push_data.eop;
            assign eop_out   = pop && head.eop;
            assign pkt_avail = (eop_cnt != '0);

            always_ff @(posedge clk) begin
                if (reset) begin
                    eop_cnt <= '0;
                end else begin
                    eop_cnt <= eop_cnt + {{PTR_W{1'b0}}, eop_in} - {{PTR_W{1'b0}}, eop_out};
                end
            end
        end else begin : g_no_cnt
            assign pkt_avail = 1'b0;
        end
    endgenerate

endmodule

//--- logic/write_arbiter.sv
// ----------------------------------------------------------------------
// write arbiter
// round-robin over ingress fifos holding a whole packet, copies the
// packet into a free buffer slot and posts its descriptor
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module write_arbiter
    import switch_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`NUM_PORTS-1:0]       pkt_avail,
    input  beat_t [`NUM_PORTS-1:0]      heads,
    output logic [`NUM_PORTS-1:0]       pop,
    input  logic                        slot_avail,
    input  logic [`SLOT_W-1:0]          free_slot,
    output logic                        wr_en,
    output logic [`ADDR_W-1:0]          wr_addr,
    output logic [`DATA_W-1:0]          wr_data,
    output logic                        desc_push,
    output pkt_desc_t                   desc
);
    logic               busy;
    logic [`PORT_W-1:0] cur;        // port being copied, also rr pointer
    logic [`SLOT_W-1:0] slot;
    logic [`BEAT_W-1:0] idx;
    logic [`PORT_W-1:0] hdr_dst;
    logic [`PRIO_W-1:0] hdr_prio;
    logic               grant;
    logic [`PORT_W-1:0] next;
    logic [`PORT_W-1:0] cand;
    beat_t              beat;
    logic [`PORT_W-1:0] dst;
    logic [`PRIO_W-1:0] prio;

    // nearest port after cur wins, cur itself last
    always_comb begin
        grant = 1'b0;
        next  = cur;
        for (int i = `NUM_PORTS; i >= 1; i--) begin
            cand = cur + i[`PORT_W-1:0];
            if (pkt_avail[cand]) begin
                grant = 1'b1;
                next  = cand;
            end
        end
        if (busy || !slot_avail) begin
            grant = 1'b0;
        end
    end

    assign beat      = heads[cur];
    assign dst       = beat.sop ? beat.data[1:0] : hdr_dst;
    assign prio      = beat.sop ? beat.data[3:2] : hdr_prio;
    assign pop       = {{(`NUM_PORTS-1){1'b0}}, busy} << cur;
    assign wr_en     = busy;
    assign wr_addr   = {slot, idx};
    assign wr_data   = beat.data;
    assign desc_push = busy && beat.eop;
    assign desc      = '{slot: slot, len: {1'b0, idx} + 4'd1, port: dst, prio: prio};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cur  <= '0;
            idx  <= '0;
        end else if (grant) begin
            busy <= 1'b1;
            cur  <= next;
            slot <= free_slot;  // held until eop, taken from free list then
            idx  <= '0;
        end else if (busy) begin
            idx      <= idx + 1'b1;
            hdr_dst  <= dst;
            hdr_prio <= prio;
            if (beat.eop) begin
                busy <= 1'b0;   // idle cycle before next grant
            end
        end
    end

endmodule

//--- logic/packet_buffer.sv
// ----------------------------------------------------------------------
// packet buffer
// shared slot memory, one write and one registered read port
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module packet_buffer (
    input  logic               clk,
    input  logic               wr_en,
    input  logic [`ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0] wr_data,
    input  logic               rd_en,
    input  logic [`ADDR_W-1:0] rd_addr,
    output logic [`DATA_W-1:0] rd_data
);
    logic [`DATA_W-1:0] mem [`NUM_SLOTS*`MAX_BEATS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];    // one cycle read latency
        end
    end

endmodule

//--- logic/queue_manager.sv
// ----------------------------------------------------------------------
// queue manager
// free slot bitmap and one descriptor fifo per egress port and priority
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module queue_manager
    import switch_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   desc_push,
    input  pkt_desc_t                              desc,
    output logic                                   slot_avail,
    output logic [`SLOT_W-1:0]                     free_slot,
    output logic [`NUM_PORTS*`NUM_PRIO-1:0]        q_nonempty,
    output pkt_desc_t [`NUM_PORTS*`NUM_PRIO-1:0]   q_heads,
    input  logic                                   desc_pop,
    input  logic [`PORT_W-1:0]                     pop_port,
    input  logic [`PRIO_W-1:0]                     pop_prio,
    input  logic                                   slot_free,
    input  logic [`SLOT_W-1:0]                     free_index
);
    logic [`NUM_SLOTS-1:0] free_map;    // 1 = slot unused

    assign slot_avail = |free_map;

    always_comb begin
        free_slot = '0;
        for (int i = `NUM_SLOTS-1; i >= 0; i--) begin
            if (free_map[i]) begin
                free_slot = i[`SLOT_W-1:0];   // lowest free ends up here
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            free_map <= '1;
        end else begin
            if (desc_push) begin
                free_map[desc.slot] <= 1'b0;
            end
            if (slot_free) begin
                free_map[free_index] <= 1'b1;
            end
        end
    end

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
        for (genvar q = 0; q < `NUM_PRIO; q++) begin : g_prio
            localparam logic [`PORT_W-1:0] PORT_ID = p;
            localparam logic [`PRIO_W-1:0] PRIO_ID = q;

            sync_fifo #(
                .entry_t    (pkt_desc_t),
                .DEPTH      (`NUM_SLOTS)
            ) desc_q (
                .clk        (clk),
                .reset      (reset),
                .push       (desc_push && desc.port == PORT_ID && desc.prio == PRIO_ID),
                .push_data  (desc),
                .pop        (desc_pop && pop_port == PORT_ID && pop_prio == PRIO_ID),
                .head       (q_heads[p*`NUM_PRIO+q]),
                .not_empty  (q_nonempty[p*`NUM_PRIO+q]),
                .free_count (),
                .pkt_avail  ()
            );
        end
    end

endmodule

//--- logic/sched_config.sv
// ----------------------------------------------------------------------
// scheduler config
// mode bit at address 0, wrr weights for priorities 0..3 at 1..4
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module sched_config
    import switch_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cfg_wr,
    input  logic [2:0] cfg_addr,
    input  logic [3:0] cfg_data,
    output sched_cfg_t cfg
);
    logic [2:0] widx;

    assign widx = cfg_addr - 3'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '{mode: 1'b0, weight: {`NUM_PRIO{4'd1}}};
        end else if (cfg_wr) begin
            if (cfg_addr == 3'd0) begin
                cfg.mode <= cfg_data[0];
            end else if (cfg_addr <= `NUM_PRIO) begin
                cfg.weight[widx[`PRIO_W-1:0]] <= cfg_data;
            end
            // other addresses ignored
        end
    end

endmodule

//--- logic/read_scheduler.sv
// ----------------------------------------------------------------------
// read scheduler
// picks egress port round-robin, priority by sp or wrr, then streams
// the packet out of the buffer and frees its slot
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module read_scheduler
    import switch_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  sched_cfg_t                           cfg,
    input  logic [`NUM_PORTS*`NUM_PRIO-1:0]      q_nonempty,
    input  pkt_desc_t [`NUM_PORTS*`NUM_PRIO-1:0] q_heads,
    output logic                                 desc_pop,
    output logic [`PORT_W-1:0]                   pop_port,
    output logic [`PRIO_W-1:0]                   pop_prio,
    output logic                                 rd_en,
    output logic [`ADDR_W-1:0]                   rd_addr,
    input  logic [`DATA_W-1:0]                   rd_data,
    output logic                                 slot_free,
    output logic [`SLOT_W-1:0]                   free_index,
    input  logic [`NUM_PORTS-1:0]                out_ready,
    output logic [`NUM_PORTS-1:0]                out_vld,
    output logic [`NUM_PORTS-1:0]                out_sop,
    output logic [`NUM_PORTS-1:0]                out_eop,
    output logic [`NUM_PORTS-1:0][`DATA_W-1:0]   out_data
);
    logic                               busy;
    pkt_desc_t                          cur;        // packet being read
    logic [`BEAT_W-1:0]                 idx;
    logic                               last_beat;
    logic [`PORT_W-1:0]                 rr_port;    // last port served
    logic [`PORT_W-1:0]                 cand;
    logic [`NUM_PORTS-1:0][`PRIO_W-1:0] wrr_prio;
    logic [`NUM_PORTS-1:0][3:0]         wrr_used;
    logic [`NUM_PRIO-1:0]               ne;
    logic [`PRIO_W-1:0]                 pcand;
    logic [3:0]                         wt;
    logic                               wrr_stay;

    always_comb begin
        desc_pop = 1'b0;
        pop_port = rr_port;
        for (int i = `NUM_PORTS; i >= 1; i--) begin
            cand = rr_port + i[`PORT_W-1:0];
            if (out_ready[cand] && |q_nonempty[cand*`NUM_PRIO +: `NUM_PRIO]) begin
                desc_pop = 1'b1;
                pop_port = cand;
            end
        end
        if (busy) begin
            desc_pop = 1'b0;
        end
    end

    assign ne       = q_nonempty[pop_port*`NUM_PRIO +: `NUM_PRIO];
    assign wt       = (cfg.weight[wrr_prio[pop_port]] == 4'd0) ? 4'd1
                                                               : cfg.weight[wrr_prio[pop_port]];
    assign wrr_stay = ne[wrr_prio[pop_port]] && (wrr_used[pop_port] < wt);

    always_comb begin
        pop_prio = '0;
        pcand    = '0;
        if (!cfg.mode) begin
            for (int i = 0; i < `NUM_PRIO; i++) begin
                if (ne[i]) begin
                    pop_prio = i[`PRIO_W-1:0];  // highest non-empty
                end
            end
        end else if (wrr_stay) begin
            pop_prio = wrr_prio[pop_port];
        end else begin
            // step downward from current, wraps 0 -> 3
            for (int i = `NUM_PRIO; i >= 1; i--) begin
                pcand = wrr_prio[pop_port] - i[`PRIO_W-1:0];
                if (ne[pcand]) begin
                    pop_prio = pcand;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            idx      <= '0;
            rr_port  <= '0;
            wrr_prio <= '1;
            wrr_used <= '0;
        end else if (desc_pop) begin
            busy    <= 1'b1;
            cur     <= q_heads[{pop_port, pop_prio}];
            idx     <= '0;
            rr_port <= pop_port;
            if (cfg.mode) begin
                wrr_prio[pop_port] <= pop_prio;
                wrr_used[pop_port] <= wrr_stay ? wrr_used[pop_port] + 4'd1 : 4'd1;
            end
        end else if (busy) begin
            idx <= idx + 1'b1;
            if (last_beat) begin
                busy <= 1'b0;   // next pop lands with this eop on the wire
            end
        end
    end

    assign rd_en      = busy;
    assign rd_addr    = {cur.slot, idx};
    assign last_beat  = busy && ({1'b0, idx} == cur.len - 4'd1);
    assign slot_free  = last_beat;
    assign free_index = cur.slot;

    // aligned with rd_data, one cycle after the read
    always_ff @(posedge clk) begin
        if (reset) begin
            out_vld <= '0;
            out_sop <= '0;
            out_eop <= '0;
        end else begin
            out_vld <= '0;
            out_sop <= '0;
            out_eop <= '0;
            if (busy) begin
                out_vld[cur.port] <= 1'b1;
                out_sop[cur.port] <= (idx == '0);
                out_eop[cur.port] <= last_beat;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            out_data[p] = out_vld[p] ? rd_data : '0;
        end
    end

endmodule

//--- logic/switch_top.sv
// ----------------------------------------------------------------------
// shared buffer switch top
// ingress fifos, write arbiter, packet memory, queues and scheduler
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module switch_top
    import switch_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cfg_wr,
    input  logic [2:0]                         cfg_addr,
    input  logic [3:0]                         cfg_data,
    input  logic [`NUM_PORTS-1:0]              in_vld,
    input  logic [`NUM_PORTS-1:0]              in_sop,
    input  logic [`NUM_PORTS-1:0]              in_eop,
    input  logic [`NUM_PORTS-1:0][`DATA_W-1:0] in_data,
    output logic [`NUM_PORTS-1:0]              in_full,
    input  logic [`NUM_PORTS-1:0]              out_ready,
    output logic [`NUM_PORTS-1:0]              out_vld,
    output logic [`NUM_PORTS-1:0]              out_sop,
    output logic [`NUM_PORTS-1:0]              out_eop,
    output logic [`NUM_PORTS-1:0][`DATA_W-1:0] out_data
);
    beat_t [`NUM_PORTS-1:0]                       heads;
    logic [`NUM_PORTS-1:0]                        pkt_avail;
    logic [`NUM_PORTS-1:0]                        in_pop;
    logic [`NUM_PORTS-1:0][$clog2(`IN_FIFO_DEPTH):0] free_cnt;

    logic                                  slot_avail;
    logic [`SLOT_W-1:0]                    free_slot;
    logic                                  wr_en;
    logic [`ADDR_W-1:0]                    wr_addr;
    logic [`DATA_W-1:0]                    wr_data;
    logic                                  desc_push;
    pkt_desc_t                             desc;
    logic [`NUM_PORTS*`NUM_PRIO-1:0]       q_nonempty;
    pkt_desc_t [`NUM_PORTS*`NUM_PRIO-1:0]  q_heads;
    logic                                  desc_pop;
    logic [`PORT_W-1:0]                    pop_port;
    logic [`PRIO_W-1:0]                    pop_prio;
    logic                                  rd_en;
    logic [`ADDR_W-1:0]                    rd_addr;
    logic [`DATA_W-1:0]                    rd_data;
    logic                                  slot_free;
    logic [`SLOT_W-1:0]                    free_index;
    sched_cfg_t                            cfg;

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_in
        sync_fifo #(
            .entry_t    (beat_t),
            .DEPTH      (`IN_FIFO_DEPTH),
            .COUNT_PKTS (1'b1)
        ) in_fifo (
            .clk        (clk),
            .reset      (reset),
            .push       (in_vld[i]),
            .push_data  ({in_sop[i], in_eop[i], in_data[i]}),
            .pop        (in_pop[i]),
            .head       (heads[i]),
            .not_empty  (),
            .free_count (free_cnt[i]),
            .pkt_avail  (pkt_avail[i])
        );
        assign in_full[i] = (free_cnt[i] < `MAX_BEATS);    // no room for a max packet
    end

    write_arbiter write_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .pkt_avail  (pkt_avail),
        .heads      (heads),
        .pop        (in_pop),
        .slot_avail (slot_avail),
        .free_slot  (free_slot),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .desc_push  (desc_push),
        .desc       (desc)
    );

    packet_buffer packet_buffer_inst (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    queue_manager queue_manager_inst (
        .clk        (clk),
        .reset      (reset),
        .desc_push  (desc_push),
        .desc       (desc),
        .slot_avail (slot_avail),
        .free_slot  (free_slot),
        .q_nonempty (q_nonempty),
        .q_heads    (q_heads),
        .desc_pop   (desc_pop),
        .pop_port   (pop_port),
        .pop_prio   (pop_prio),
        .slot_free  (slot_free),
        .free_index (free_index)
    );

    sched_config sched_config_inst (
        .clk        (clk),
        .reset      (reset),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .cfg        (cfg)
    );

    read_scheduler read_scheduler_inst (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .q_nonempty (q_nonempty),
        .q_heads    (q_heads),
        .desc_pop   (desc_pop),
        .pop_port   (pop_port),
        .pop_prio   (pop_prio),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .slot_free  (slot_free),
        .free_index (free_index),
        .out_ready  (out_ready),
        .out_vld    (out_vld),
        .out_sop    (out_sop),
        .out_eop    (out_eop),
        .out_data   (out_data)
    );

endmodule

//--- testbench/switch_tb.sv
// ----------------------------------------------------------------------
// switch testbench
// random traffic, ordering, strict priority, wrr and buffer exhaustion
// with a per source, destination and priority scoreboard
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "switch_macros.svh"

module switch_tb;
    localparam int BEATS_SENT = 40*8 + 12*8 + 6*8 + 9*8 + 20*8;
    localparam int CYCLE_LIMIT = BEATS_SENT*4 + 3000;

    logic                               clk = 1'b0;
    logic                               reset = 1'b1;
    logic                               cfg_wr = 1'b0;
    logic [2:0]                         cfg_addr = '0;
    logic [3:0]                         cfg_data = '0;
    logic [`NUM_PORTS-1:0]              in_vld = '0;
    logic [`NUM_PORTS-1:0]              in_sop = '0;
    logic [`NUM_PORTS-1:0]              in_eop = '0;
    logic [`NUM_PORTS-1:0][`DATA_W-1:0] in_data = '0;
    logic [`NUM_PORTS-1:0]              in_full;
    logic [`NUM_PORTS-1:0]              out_ready = '1;
    logic [`NUM_PORTS-1:0]              out_vld;
    logic [`NUM_PORTS-1:0]              out_sop;
    logic [`NUM_PORTS-1:0]              out_eop;
    logic [`NUM_PORTS-1:0][`DATA_W-1:0] out_data;

    logic [33:0] exp_q [64][$];     // key = src*16 + dst*4 + prio
    int          sop_prio [4][$];   // egress priority order per port
    int          want_order [$];
    int          wrr_cnt [4];
    int          wrr_w [4];
    int          cur_key [4];
    logic [3:0]  in_pkt = '0;
    int          pending = 0;
    int          errors = 0;
    int          beats_checked = 0;
    int          failed_tests = 0;
    int          cycles = 0;
    int          mark;
    logic        full_seen;
    logic        sent_all;

    switch_top switch_top_inst (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped, no progress after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic flag(input string msg);
        $display("FAIL @%0t: %s", $time, msg);
        errors++;
    endtask

    // egress checker
    always @(posedge clk) begin : monitor
        logic [33:0] got;
        logic [33:0] want;
        if (!reset) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                got = {out_sop[p], out_eop[p], out_data[p]};
                if (out_vld[p]) begin
                    if (out_sop[p]) begin
                        assert (!in_pkt[p]) else flag($sformatf("port %0d sop inside packet", p));
                        assert (out_data[p][1:0] == p[1:0])
                            else flag($sformatf("port %0d got packet for other port", p));
                        cur_key[p] = out_data[p][5:4]*16 + out_data[p][1:0]*4 + out_data[p][3:2];
                        sop_prio[p].push_back(int'(out_data[p][3:2]));
                        in_pkt[p] = 1'b1;
                    end
                    assert (in_pkt[p]) else flag($sformatf("port %0d beat without sop", p));
                    if (in_pkt[p]) begin
                        if (exp_q[cur_key[p]].size() == 0) begin
                            flag($sformatf("port %0d unexpected beat %h", p, got));
                        end else begin
                            want = exp_q[cur_key[p]].pop_front();
                            assert (got == want)
                                else flag($sformatf("port %0d beat %h, want %h", p, got, want));
                            pending--;
                            beats_checked++;
                        end
                        if (out_eop[p]) in_pkt[p] = 1'b0;
                    end
                end else begin
                    assert (!in_pkt[p]) else begin
                        flag($sformatf("port %0d out_vld dropped inside packet", p));
                        in_pkt[p] = 1'b0;
                    end
                end
            end
        end
    end

    task automatic send_pkt(input int src, input int dst, input int prio, input int len);
        logic [31:0] w;
        logic [1:0]  s2;
        logic [1:0]  d2;
        logic [1:0]  p2;
        s2 = src[1:0];
        d2 = dst[1:0];
        p2 = prio[1:0];
        do @(negedge clk); while (in_full[src]);   // room for a max packet
        for (int i = 0; i < len; i++) begin
            w = $urandom;
            if (i == 0) w[5:0] = {s2, p2, d2};
            exp_q[src*16 + dst*4 + prio].push_back({i == 0, i == len-1, w});
            pending++;
            @(posedge clk);
            in_vld[src]  <= 1'b1;
            in_sop[src]  <= (i == 0);
            in_eop[src]  <= (i == len-1);
            in_data[src] <= w;
        end
        @(posedge clk);
        in_vld[src] <= 1'b0;
    endtask

    task automatic send_random(input int src, input int n);
        for (int i = 0; i < n; i++) begin
            send_pkt(src, $urandom_range(0, 3), $urandom_range(0, 3), $urandom_range(1, 8));
        end
    endtask

    // until every sent beat is out, or egress has gone quiet
    task automatic wait_drain();
        int quiet;
        quiet = 0;
        do begin
            @(negedge clk);
            quiet = (out_vld == '0) ? quiet + 1 : 0;
        end while (pending != 0 && quiet < 200);
    endtask

    // all ingress packets copied into the buffer
    task automatic wait_stored();
        do @(negedge clk);
        while (switch_top_inst.pkt_avail != 0 || switch_top_inst.wr_en);
    endtask

    task automatic write_cfg(input logic [2:0] a, input logic [3:0] d);
        @(posedge clk);
        cfg_wr   <= 1'b1;
        cfg_addr <= a;
        cfg_data <= d;
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    // reference order for one port, starting from prio 3 with nothing used
    task automatic build_wrr_order();
        int cur;
        int used;
        int total;
        int wt;
        int pick;
        cur = 3;
        used = 0;
        total = wrr_cnt[0] + wrr_cnt[1] + wrr_cnt[2] + wrr_cnt[3];
        want_order.delete();
        while (total > 0) begin
            wt = (wrr_w[cur] == 0) ? 1 : wrr_w[cur];
            if (!(wrr_cnt[cur] > 0 && used < wt)) begin
                pick = cur;
                for (int step = 1; step <= 4; step++) begin
                    if (wrr_cnt[(cur + 4 - step) % 4] > 0) begin
                        pick = (cur + 4 - step) % 4;
                        break;
                    end
                end
                cur = pick;
                used = 0;
            end
            want_order.push_back(cur);
            wrr_cnt[cur]--;
            used++;
            total--;
        end
    endtask

    task automatic compare_order(input int p);
        assert (sop_prio[p].size() == want_order.size())
            else flag($sformatf("port %0d sent %0d packets, want %0d", p,
                                sop_prio[p].size(), want_order.size()));
        for (int i = 0; i < want_order.size() && i < sop_prio[p].size(); i++) begin
            assert (sop_prio[p][i] == want_order[i])
                else flag($sformatf("port %0d packet %0d prio %0d, want %0d", p, i,
                                    sop_prio[p][i], want_order[i]));
        end
    endtask

    task automatic check_empty();
        for (int k = 0; k < 64; k++) begin
            assert (exp_q[k].size() == 0)
                else flag($sformatf("queue %0d has %0d beats never delivered", k, exp_q[k].size()));
        end
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: %s", num, name, (errors == mark) ? "pass" : "fail");
        if (errors != mark) failed_tests++;
        mark = errors;
    endtask

    initial begin
        void'($urandom(32'h45758bfb));
        mark = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        assert (out_vld == '0 && in_full == '0) else flag("outputs not idle after reset");
        report(1, "reset state");

        fork
            send_random(0, 10);
            send_random(1, 10);
            send_random(2, 10);
            send_random(3, 10);
        join
        wait_drain();
        check_empty();
        report(2, "random traffic");

        fork
            for (int i = 0; i < 6; i++) send_pkt(3, 0, 1, $urandom_range(1, 8));
            send_random(0, 2);
            send_random(1, 2);
            send_random(2, 2);
        join
        wait_drain();
        check_empty();
        report(3, "per flow order");

        @(posedge clk);
        out_ready[2] <= 1'b0;
        sop_prio[2].delete();
        for (int i = 0; i < 2; i++) begin
            send_pkt(0, 2, 0, $urandom_range(1, 8));
            send_pkt(0, 2, 1, $urandom_range(1, 8));
            send_pkt(0, 2, 3, $urandom_range(1, 8));
        end
        wait_stored();
        want_order = '{3, 3, 1, 1, 0, 0};
        @(posedge clk);
        out_ready[2] <= 1'b1;
        wait_drain();
        compare_order(2);
        report(4, "strict priority");

        write_cfg(3'd0, 4'd1);
        write_cfg(3'd4, 4'd2);      // prio 3 weight
        @(posedge clk);
        out_ready[1] <= 1'b0;
        sop_prio[1].delete();
        for (int i = 0; i < 3; i++) begin
            send_pkt(1, 1, 0, $urandom_range(1, 8));
            send_pkt(1, 1, 2, $urandom_range(1, 8));
            send_pkt(1, 1, 3, $urandom_range(1, 8));
        end
        wait_stored();
        wrr_cnt = '{3, 0, 3, 3};
        wrr_w = '{1, 1, 1, 2};
        build_wrr_order();
        @(posedge clk);
        out_ready[1] <= 1'b1;
        wait_drain();
        compare_order(1);
        report(5, "weighted round robin");

        full_seen = 1'b0;
        sent_all  = 1'b0;
        @(posedge clk);
        out_ready <= '0;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    send_pkt(0, $urandom_range(0, 3), $urandom_range(0, 3), 8);
                end
                sent_all = 1'b1;
            end
            begin
                do @(negedge clk); while (!in_full[0] && !sent_all);
                full_seen = in_full[0];
                @(posedge clk);
                out_ready <= '1;
            end
        join
        wait_drain();
        assert (full_seen) else flag("in_full never rose with buffer full");
        check_empty();
        report(6, "buffer exhaustion");

        $display("tests 6, failed tests %0d, beats checked %0d, errors %0d",
                 failed_tests, beats_checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
logic/switch_pkg.sv
logic/sync_fifo.sv
logic/write_arbiter.sv
logic/packet_buffer.sv
logic/queue_manager.sv
logic/sched_config.sv
logic/read_scheduler.sv
logic/switch_top.sv
testbench/switch_tb.sv

//--- Makefile
.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module switch_tb \
		-o switch_sim --Mdir obj_dir

run: build
	./obj_dir/switch_sim | tee run.log
	grep -q "TEST OK" run.log

clean:
	rm -rf obj_dir run.log
